/* gat_layer.f */
+incdir+include
design/gat_pkg.sv
design/coef_unit.sv
design/coef_fifo.sv
design/aggregator.sv
design/gat_layer.sv
verification/gat_layer_tb.sv

/* verification/gat_layer_tb.sv */
`timescale 1ns/10ps
`include "gat_cfg.svh"

module gat_layer_tb;
  import gat_pkg::*;

  localparam int NUM_SUB  = 4;
  localparam int TIMEOUT  = 2000;
  localparam int NUM_GAPS = 16;

  logic       clk;
  logic       rst_n;
  logic       in_valid;
  wh_row_t    in_row;
  logic       in_credit;
  attn_vec_t  attn;
  logic       out_valid;
  feat_out_t  out_feat;
  logic       out_credit;

  wh_row_t    tbl_row [NUM_SUB][`GAT_MAX_NODES];
  int         tbl_len [NUM_SUB];
  feat_out_t  tbl_exp [NUM_SUB];
  wh_row_t    send_q[$];
  feat_out_t  exp_q[$];

  // Random gaps before each returned output credit
  int gap_tbl [NUM_GAPS];
  int gap_idx;

  int in_credits;
  int credit_pulses;
  int rows_sent;
  int results;
  int owed_credits;
  int gap_cnt;
  bit hold_credits;

  gat_layer u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid_i   (in_valid),
    .in_row_i     (in_row),
    .in_credit_o  (in_credit),
    .attn_i       (attn),
    .out_valid_o  (out_valid),
    .out_feat_o   (out_feat),
    .out_credit_i (out_credit)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TB FAILED");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check_feat(input feat_out_t got, input feat_out_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0t: out_feat_o %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic check_credits(input int got, input int exp, input string what);
    if (got != exp) begin
      abort_run($sformatf("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic set_row(input int e, input int r, input int f0, input int f1,
                         input int f2, input int f3);
    tbl_row[e][r].feat[0] = feat_t'(f0);
    tbl_row[e][r].feat[1] = feat_t'(f1);
    tbl_row[e][r].feat[2] = feat_t'(f2);
    tbl_row[e][r].feat[3] = feat_t'(f3);
    tbl_row[e][r].first   = (r == 0);
    tbl_row[e][r].last    = 1'b0;
    tbl_len[e]            = r + 1;
  endtask

  // Leaky ReLU of self plus neighbour score, summed as coef times row
  function automatic feat_out_t expected_out(input int e);
    feat_out_t res;
    int        self_dot;
    int        coef;
    res      = '0;
    self_dot = 0;
    for (int k = 0; k < `GAT_NUM_FEAT; k++) begin
      self_dot += attn.a_self[k] * tbl_row[e][0].feat[k];
    end
    for (int r = 0; r < tbl_len[e]; r++) begin
      coef = self_dot;
      for (int k = 0; k < `GAT_NUM_FEAT; k++) begin
        coef += attn.a_neigh[k] * tbl_row[e][r].feat[k];
      end
      if (coef < 0) coef = coef >>> `GAT_LRELU_SHIFT;
      for (int k = 0; k < `GAT_NUM_FEAT; k++) begin
        res.sum[k] += coef * tbl_row[e][r].feat[k];
      end
    end
    return res;
  endfunction

  task automatic build_table();
    // Single row
    set_row(0, 0, 2, 1, 3, 1);
    // Positive scores
    set_row(1, 0, 3, 2, 1, 1);
    set_row(1, 1, 1, 2, 0, 1);
    set_row(1, 2, 2, 0, 1, 3);
    // Negative scores
    set_row(2, 0, -4, -2, -1, -3);
    set_row(2, 1, 1, -2, 3, -1);
    set_row(2, 2, -1, 1, 2, 0);
    // Mixed signs
    set_row(3, 0, 5, -1, 0, 2);
    set_row(3, 1, 0, 3, -2, 1);
    set_row(3, 2, -3, -3, 4, -2);
    set_row(3, 3, 1, 1, 1, 1);
    for (int e = 0; e < NUM_SUB; e++) begin
      tbl_row[e][tbl_len[e]-1].last = 1'b1;
      tbl_exp[e] = expected_out(e);
    end
  endtask

  task automatic enqueue_table();
    for (int e = 0; e < NUM_SUB; e++) begin
      for (int r = 0; r < tbl_len[e]; r++) send_q.push_back(tbl_row[e][r]);
      exp_q.push_back(tbl_exp[e]);
    end
  endtask

  task automatic wait_results(input int target);
    int n;
    n = 0;
    while (results < target) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) abort_run("Timed out waiting for output results");
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (send_q.size() != 0 || owed_credits != 0) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) abort_run("Timed out waiting for all output credits to be returned");
    end
  endtask

  task automatic wait_stall();
    int n;
    n = 0;
    while (in_credits != 0) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) abort_run("Timed out waiting for the producer to run out of credits");
    end
  endtask

  // Monitor, producer and consumer share one falling edge process
  always @(negedge clk) begin
    if (rst_n) begin
      if (in_credit) begin
        in_credits++;
        credit_pulses++;
        if (in_credits > `GAT_FIFO_DEPTH) begin
          abort_run($sformatf("Fail at %0t: producer holds %0d input credits", $time,
                              in_credits));
        end
      end
      if (out_valid) begin
        if (exp_q.size() == 0) abort_run("Output result arrived with none expected");
        check_feat(out_feat, exp_q.pop_front());
        results++;
        owed_credits++;
      end
      if (send_q.size() != 0 && in_credits > 0) begin
        in_row = send_q.pop_front();
        in_valid = 1'b1;
        in_credits--;
        rows_sent++;
      end else begin
        in_valid = 1'b0;
      end
      out_credit = 1'b0;
      if (!hold_credits && owed_credits > 0) begin
        if (gap_cnt == 0) begin
          out_credit = 1'b1;
          owed_credits--;
          gap_cnt = gap_tbl[gap_idx % NUM_GAPS];
          gap_idx++;
        end else begin
          gap_cnt--;
        end
      end
    end
  end

  initial begin
    int base;
    void'($urandom(86767));
    foreach (gap_tbl[i]) gap_tbl[i] = $urandom_range(3, 0);
    rst_n         = 1'b0;
    in_valid      = 1'b0;
    in_row        = '0;
    out_credit    = 1'b0;
    attn.a_self   = {8'sd1, 8'sd1, 8'sd1, 8'sd1};
    attn.a_neigh  = {8'sd2, -8'sd1, 8'sd0, 8'sd1};
    hold_credits  = 1'b0;
    in_credits    = `GAT_FIFO_DEPTH;
    credit_pulses = 0;
    rows_sent     = 0;
    results       = 0;
    owed_credits  = 0;
    gap_cnt       = gap_tbl[0];
    gap_idx       = 1;
    build_table();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Idle after reset
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      if (out_valid || in_credit) abort_run("Output or credit pulse while idle after reset");
    end

    // Back-to-back subgraphs at full credit rate
    @(posedge clk);
    enqueue_table();
    wait_results(NUM_SUB);
    wait_idle();
    check_credits(credit_pulses, rows_sent, "in_credit_o pulses");

    // Withheld output credits back-pressure the producer
    @(posedge clk);
    base = results;
    hold_credits = 1'b1;
    enqueue_table();
    enqueue_table();
    wait_stall();
    repeat (20) @(posedge clk);
    if (results - base > `GAT_OUT_CREDITS) begin
      abort_run($sformatf("Fail at %0t: %0d results with output credits withheld", $time,
                          results - base));
    end
    hold_credits = 1'b0;
    wait_results(base + 2 * NUM_SUB);
    wait_idle();
    check_credits(credit_pulses, rows_sent, "in_credit_o pulses");

    $display("TB PASSED");
    $finish;
  end

endmodule

/* design/gat_layer.sv */
`timescale 1ns/10ps

module gat_layer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid_i,
  input  gat_pkg::wh_row_t     in_row_i,
  output logic                 in_credit_o,
  input  gat_pkg::attn_vec_t   attn_i,
  output logic                 out_valid_o,
  output gat_pkg::feat_out_t   out_feat_o,
  input  logic                 out_credit_i
);
  import gat_pkg::*;

  logic        push;
  scored_row_t push_data;
  logic        pop;
  logic        empty;
  scored_row_t rd_data;

  coef_unit u_coef_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid_i),
    .in_row_i    (in_row_i),
    .attn_i      (attn_i),
    .push_o      (push),
    .push_data_o (push_data)
  );

  // Each pop frees one input credit
  coef_fifo u_coef_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .rd_data_o   (rd_data),
    .empty_o     (empty),
    .credit_o    (in_credit_o)
  );

  aggregator u_aggregator (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_data_i    (rd_data),
    .empty_i      (empty),
    .pop_o        (pop),
    .out_credit_i (out_credit_i),
    .out_valid_o  (out_valid_o),
    .out_feat_o   (out_feat_o)
  );

endmodule

/* design/aggregator.sv */
`timescale 1ns/10ps
`include "gat_cfg.svh"

module aggregator (
  input  logic                  clk,
  input  logic                  rst_n,
  input  gat_pkg::scored_row_t  rd_data_i,
  input  logic                  empty_i,
  output logic                  pop_o,
  input  logic                  out_credit_i,
  output logic                  out_valid_o,
  output gat_pkg::feat_out_t    out_feat_o
);
  import gat_pkg::*;

  localparam int NF        = `GAT_NUM_FEAT;
  // One spare bit so an excess credit return is visible
  localparam int CRED_W    = $clog2(`GAT_OUT_CREDITS + 2);
  localparam int ROW_CNT_W = $clog2(`GAT_MAX_NODES + 1);

  logic [CRED_W-1:0]    credit_cnt_q;
  logic [ROW_CNT_W-1:0] row_cnt_q;
  logic                 head_last;
  logic                 emit_take;
  acc_t                 acc_q   [NF];
  acc_t                 acc_nxt [NF];

  // Last row waits in the FIFO until an output credit is held
  assign head_last = rd_data_i.row.last;
  assign pop_o     = !empty_i && (!head_last || (credit_cnt_q != '0));
  assign emit_take = pop_o && head_last;

  always_comb begin
    for (int k = 0; k < NF; k++) begin
      acc_nxt[k] = rd_data_i.coef * rd_data_i.row.feat[k];
      if (!rd_data_i.row.first) begin
        acc_nxt[k] = acc_nxt[k] + acc_q[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop_o) begin
      acc_q <= acc_nxt;
    end
    if (emit_take) begin
      for (int k = 0; k < NF; k++) begin
        out_feat_o.sum[k] <= acc_nxt[k];
      end
    end
  end

  // Credit is taken when the emit is committed at the last pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_cnt_q <= CRED_W'(`GAT_OUT_CREDITS);
      out_valid_o  <= 1'b0;
      row_cnt_q    <= '0;
    end else begin
      credit_cnt_q <= credit_cnt_q - CRED_W'(emit_take) + CRED_W'(out_credit_i);
      out_valid_o  <= emit_take;
      if (pop_o) begin
        row_cnt_q <= head_last ? '0 : row_cnt_q + 1'b1;
      end
    end
  end

  a_credit_bound: assert property (
    @(posedge clk) disable iff (!rst_n)
    credit_cnt_q <= CRED_W'(`GAT_OUT_CREDITS)
  ) else $error("aggregator output credits above grant");

  // Subgraph must end within the node limit
  a_subgraph_size: assert property (
    @(posedge clk) disable iff (!rst_n)
    pop_o |-> row_cnt_q < ROW_CNT_W'(`GAT_MAX_NODES)
  ) else $error("aggregator subgraph longer than max nodes");

endmodule

/* design/coef_fifo.sv */
`timescale 1ns/10ps
`include "gat_cfg.svh"

module coef_fifo (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push_i,
  input  gat_pkg::scored_row_t  push_data_i,
  input  logic                  pop_i,
  output gat_pkg::scored_row_t  rd_data_o,
  output logic                  empty_o,
  output logic                  credit_o
);
  import gat_pkg::*;

  localparam int DEPTH = `GAT_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  scored_row_t      mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full      = (count_q == CNT_W'(DEPTH));
  assign empty_o   = (count_q == '0);
  assign rd_data_o = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      credit_o <= pop_i;
      if (push_i) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop_i) rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Input credits must keep the producer from overrunning
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push_i |-> !full)
    else $error("coef_fifo push while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o)
    else $error("coef_fifo pop while empty");

endmodule

/* design/coef_unit.sv */
`timescale 1ns/10ps
`include "gat_cfg.svh"

module coef_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid_i,
  input  gat_pkg::wh_row_t      in_row_i,
  input  gat_pkg::attn_vec_t    attn_i,
  output logic                  push_o,
  output gat_pkg::scored_row_t  push_data_o
);
  import gat_pkg::*;

  logic    s1_valid_q;
  wh_row_t s1_row_q;
  coef_t   neigh_score_q;
  coef_t   self_score_q;
  coef_t   score_sum;
  coef_t   score_lrelu;
  logic    seen_first_q;

  function automatic coef_t dot4(
    input feat_t [`GAT_NUM_FEAT-1:0] a,
    input feat_t [`GAT_NUM_FEAT-1:0] x
  );
    coef_t acc;
    acc = '0;
    for (int k = 0; k < `GAT_NUM_FEAT; k++) begin
      acc += a[k] * x[k];
    end
    return acc;
  endfunction

  // Stage 1 control
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q   <= 1'b0;
      seen_first_q <= 1'b0;
    end else begin
      s1_valid_q <= in_valid_i;
      if (in_valid_i && in_row_i.first) begin
        seen_first_q <= 1'b1;
      end
    end
  end

  // Self score is held until the next target row
  always_ff @(posedge clk) begin
    if (in_valid_i) begin
      s1_row_q      <= in_row_i;
      neigh_score_q <= dot4(attn_i.a_neigh, in_row_i.feat);
      if (in_row_i.first) begin
        self_score_q <= dot4(attn_i.a_self, in_row_i.feat);
      end
    end
  end

  // Leaky ReLU, floor on negative values
  assign score_sum   = self_score_q + neigh_score_q;
  assign score_lrelu = score_sum[`GAT_COEF_W-1] ? (score_sum >>> `GAT_LRELU_SHIFT) : score_sum;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push_o <= 1'b0;
    end else begin
      push_o <= s1_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid_q) begin
      push_data_o.row  <= s1_row_q;
      push_data_o.coef <= score_lrelu;
    end
  end

  a_first_before_neigh: assert property (
    @(posedge clk) disable iff (!rst_n)
    in_valid_i && !in_row_i.first |-> seen_first_q
  ) else $error("coef_unit neighbour row before any target row");

endmodule

/* design/gat_pkg.sv */
`include "gat_cfg.svh"

package gat_pkg;

  typedef logic signed [`GAT_FEAT_W-1:0] feat_t;
  typedef logic signed [`GAT_COEF_W-1:0] coef_t;
  typedef logic signed [`GAT_ACC_W-1:0]  acc_t;

  // One transformed feature row
  typedef struct packed {
    feat_t [`GAT_NUM_FEAT-1:0] feat;
    logic                      first;
    logic                      last;
  } wh_row_t;

  typedef struct packed {
    feat_t [`GAT_NUM_FEAT-1:0] a_self;
    feat_t [`GAT_NUM_FEAT-1:0] a_neigh;
  } attn_vec_t;

  // FIFO word
  typedef struct packed {
    wh_row_t row;
    coef_t   coef;
  } scored_row_t;

  typedef struct packed {
    acc_t [`GAT_NUM_FEAT-1:0] sum;
  } feat_out_t;

endpackage

/* include/gat_cfg.svh */
`ifndef GAT_CFG_SVH
`define GAT_CFG_SVH

// Row element and feature count
`define GAT_FEAT_W      8
`define GAT_NUM_FEAT    4
`define GAT_MAX_NODES   8

// Two 4-term dot products plus sign
`define GAT_COEF_W      20
`define GAT_ACC_W       32

// FIFO depth doubles as the input credit count
`define GAT_FIFO_DEPTH  8
`define GAT_OUT_CREDITS 2

// Leaky ReLU slope for negative scores, 1/8
`define GAT_LRELU_SHIFT 3

`endif
